// File: include/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Fetch address after reset
`define PC_START 32'h0000_0000

// Pattern table index width, also the global history length
`define GHR_BITS 5

// Target buffer entries as log2
`define BTB_BITS 5

// Architectural integer registers
`define RF_ENTRIES 32

`endif

// File: source/coreTypes_pkg.sv
package coreTypes_pkg;

    // RV32I major opcodes handled by the core
    typedef enum logic [6:0] {
        opImm    = 7'b0010011,
        opReg    = 7'b0110011,
        opLui    = 7'b0110111,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111
    } opcode_e;

    typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt} aluOp_e;

    typedef enum logic [2:0] {immI, immB, immJ, immU} immSel_e;

    typedef enum logic {fwdReg, fwdWb} fwdSel_e; // Register file or writeback result

    typedef enum logic [1:0] {resAlu, resPc4, resImm} resultSel_e;

    // One instruction word, seen as R-type fields or as I-type fields
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            opcode_e    op;
        } rView;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            opcode_e     op;
        } iView;
    } instrWord_u;

endpackage

// File: source/branchPredictor.sv
`include "core_defs.svh"

module branchPredictor (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [31:0]          pcF_i,
    output logic                 predTakenF_o,
    output logic [31:0]          predTargetF_o,
    output logic [`GHR_BITS-1:0] phtIdxF_o,
    input  logic                 phtWeE_i,
    input  logic                 phtIncE_i,
    input  logic [`GHR_BITS-1:0] phtIdxE_i,
    input  logic                 ghrClearE_i,
    input  logic                 btbWeE_i,
    input  logic [`BTB_BITS-1:0] btbIdxE_i,
    input  logic [31:0]          btbTargetE_i
);

    localparam int PhtSize = 1 << `GHR_BITS;
    localparam int BtbSize = 1 << `BTB_BITS;
    localparam int TagBits = 30 - `BTB_BITS;

    logic [1:0]           pht [PhtSize];       // 2-bit saturating counters
    logic [`GHR_BITS-1:0] ghr;
    logic [BtbSize-1:0]   btbValid;
    logic [TagBits-1:0]   btbTag [BtbSize];
    logic [31:0]          btbTarget [BtbSize];
    logic [TagBits-1:0]   tagD;
    logic [TagBits-1:0]   tagE;
    logic [`BTB_BITS-1:0] btbIdxF;
    logic                 btbHitF;

    // Gshare style index
    assign phtIdxF_o = pcF_i[`GHR_BITS+1:2] ^ ghr;

    assign btbIdxF = pcF_i[`BTB_BITS+1:2];
    assign btbHitF = btbValid[btbIdxF] && (btbTag[btbIdxF] == pcF_i[31:`BTB_BITS+2]);

    assign predTakenF_o  = pht[phtIdxF_o][1] && btbHitF;
    assign predTargetF_o = btbTarget[btbIdxF];

    always_ff @(posedge clk) begin
        if (reset) begin
            ghr      <= '0;
            btbValid <= '0;
            for (int i = 0; i < PhtSize; i++) begin
                pht[i] <= 2'b01; // Weakly not taken
            end
        end else begin
            if (ghrClearE_i) begin
                ghr <= '0;
            end else if (phtWeE_i) begin
                ghr <= {ghr[`GHR_BITS-2:0], phtIncE_i};
            end
            if (phtWeE_i) begin
                if (phtIncE_i && pht[phtIdxE_i] != 2'b11) begin
                    pht[phtIdxE_i] <= pht[phtIdxE_i] + 2'b01;
                end else if (!phtIncE_i && pht[phtIdxE_i] != 2'b00) begin
                    pht[phtIdxE_i] <= pht[phtIdxE_i] - 2'b01;
                end
            end
            if (btbWeE_i) begin
                btbValid[btbIdxE_i] <= 1'b1;
            end
        end
    end

    // No stalls in the core, so the fetch tag two cycles back belongs to execute
    always_ff @(posedge clk) begin
        tagD <= pcF_i[31:`BTB_BITS+2];
        tagE <= tagD;
        if (btbWeE_i) begin
            btbTag[btbIdxE_i]    <= tagE;
            btbTarget[btbIdxE_i] <= btbTargetE_i;
        end
    end

endmodule

// File: source/controlUnit.sv
module controlUnit import coreTypes_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  instrWord_u instrD_i,
    input  logic [4:0] rs1E_i,
    input  logic [4:0] rs2E_i,
    input  logic [4:0] rdW_i,
    input  logic       regWriteW_i,
    input  logic       redirectE_i,
    output immSel_e    immSelD_o,
    output aluOp_e     aluOpE_o,
    output logic       aluSrcImmE_o,
    output resultSel_e resultSelE_o,
    output logic       regWriteE_o,
    output logic       isBranchE_o,
    output logic       isJumpE_o,
    output logic       isJalrE_o,
    output logic       branchNeE_o,
    output fwdSel_e    fwdAE_o,
    output fwdSel_e    fwdBE_o,
    output logic       flushD_o,
    output logic       flushE_o
);

    aluOp_e     aluFunctD;
    aluOp_e     aluOpD;
    logic       aluSrcImmD;
    resultSel_e resultSelD;
    logic       regWriteD;
    logic       isBranchD;
    logic       isJumpD;
    logic       isJalrD;

    // ALU decoder from funct3, funct7[5] picks sub for register forms only
    always_comb begin
        case (instrD_i.rView.funct3)
            3'b000: begin
                aluFunctD = (instrD_i.rView.op == opReg && instrD_i.rView.funct7[5]) ?
                            aluSub : aluAdd;
            end
            3'b010:  aluFunctD = aluSlt;
            3'b100:  aluFunctD = aluXor;
            3'b110:  aluFunctD = aluOr;
            3'b111:  aluFunctD = aluAnd;
            default: aluFunctD = aluAdd;
        endcase
    end

    // Main decoder
    always_comb begin
        immSelD_o  = immI;
        aluOpD     = aluAdd;
        aluSrcImmD = 1'b0;
        resultSelD = resAlu;
        regWriteD  = 1'b0;
        isBranchD  = 1'b0;
        isJumpD    = 1'b0;
        isJalrD    = 1'b0;
        case (instrD_i.rView.op)
            opReg: begin
                aluOpD    = aluFunctD;
                regWriteD = 1'b1;
            end
            opImm: begin
                aluOpD     = aluFunctD;
                aluSrcImmD = 1'b1;
                regWriteD  = 1'b1;
            end
            opLui: begin
                immSelD_o  = immU;
                resultSelD = resImm;
                regWriteD  = 1'b1;
            end
            opBranch: begin
                immSelD_o = immB;
                aluOpD    = aluSub; // Equality through the zero flag
                isBranchD = 1'b1;
            end
            opJal: begin
                immSelD_o  = immJ;
                resultSelD = resPc4;
                regWriteD  = 1'b1;
                isJumpD    = 1'b1;
            end
            opJalr: begin
                aluSrcImmD = 1'b1; // rs1 + imm gives the target
                resultSelD = resPc4;
                regWriteD  = 1'b1;
                isJumpD    = 1'b1;
                isJalrD    = 1'b1;
            end
            default: ; // Bubble or unsupported, no side effects
        endcase
    end

    // Execute stage controls
    always_ff @(posedge clk) begin
        if (reset || flushE_o) begin
            aluOpE_o     <= aluAdd;
            aluSrcImmE_o <= 1'b0;
            resultSelE_o <= resAlu;
            regWriteE_o  <= 1'b0;
            isBranchE_o  <= 1'b0;
            isJumpE_o    <= 1'b0;
            isJalrE_o    <= 1'b0;
            branchNeE_o  <= 1'b0;
        end else begin
            aluOpE_o     <= aluOpD;
            aluSrcImmE_o <= aluSrcImmD;
            resultSelE_o <= resultSelD;
            regWriteE_o  <= regWriteD;
            isBranchE_o  <= isBranchD;
            isJumpE_o    <= isJumpD;
            isJalrE_o    <= isJalrD;
            branchNeE_o  <= instrD_i.rView.funct3[0];
        end
    end

    // Writeback to execute bypass
    assign fwdAE_o = (regWriteW_i && rdW_i != 5'd0 && rdW_i == rs1E_i) ? fwdWb : fwdReg;
    assign fwdBE_o = (regWriteW_i && rdW_i != 5'd0 && rdW_i == rs2E_i) ? fwdWb : fwdReg;

    // Wrong path sits in fetch and decode
    assign flushD_o = redirectE_i;
    assign flushE_o = redirectE_i;

endmodule

// File: source/datapath.sv
`include "core_defs.svh"

module datapath import coreTypes_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [31:0]          instrF_i,
    output logic [31:0]          pcF_o,
    input  logic                 predTakenF_i,
    input  logic [31:0]          predTargetF_i,
    input  logic [`GHR_BITS-1:0] phtIdxF_i,
    output logic                 phtWeE_o,
    output logic                 phtIncE_o,
    output logic [`GHR_BITS-1:0] phtIdxE_o,
    output logic                 ghrClearE_o,
    output logic                 btbWeE_o,
    output logic [`BTB_BITS-1:0] btbIdxE_o,
    output logic [31:0]          btbTargetE_o,
    output instrWord_u           instrD_o,
    output logic [4:0]           rs1E_o,
    output logic [4:0]           rs2E_o,
    output logic [4:0]           rdE_o,
    input  immSel_e              immSelD_i,
    input  aluOp_e               aluOpE_i,
    input  logic                 aluSrcImmE_i,
    input  resultSel_e           resultSelE_i,
    input  logic                 regWriteE_i,
    input  logic                 isBranchE_i,
    input  logic                 isJumpE_i,
    input  logic                 isJalrE_i,
    input  logic                 branchNeE_i,
    input  fwdSel_e              fwdAE_i,
    input  fwdSel_e              fwdBE_i,
    input  logic                 flushD_i,
    input  logic                 flushE_i,
    output logic                 redirectE_o,
    output logic [4:0]           rdW_o,
    output logic                 regWriteW_o,
    output logic [31:0]          resultW_o
);

    logic [31:0] regFile [`RF_ENTRIES];

    // Fetch
    logic [31:0] pcPlus4F;
    logic [31:0] pcNextF;
    logic [31:0] correctPcE;

    // Decode
    logic [31:0]          pcD;
    logic [31:0]          predTargetD;
    logic                 predTakenD;
    logic [`GHR_BITS-1:0] phtIdxD;
    logic [4:0]           rs1D;
    logic [4:0]           rs2D;
    logic [31:0]          rd1D;
    logic [31:0]          rd2D;
    logic [31:0]          immD;

    // Execute
    logic [31:0] pcE;
    logic [31:0] predTargetE;
    logic        predTakenE;
    logic [31:0] rd1E;
    logic [31:0] rd2E;
    logic [31:0] immE;
    logic [31:0] srcAE;
    logic [31:0] srcBRegE;
    logic [31:0] srcBE;
    logic [31:0] aluResultE;
    logic [31:0] targetE;
    logic [31:0] pcPlus4E;
    logic        zeroE;
    logic        condE;
    logic        takenE;

    // Writeback
    logic [31:0] aluResultW;
    logic [31:0] pcPlus4W;
    logic [31:0] immW;
    resultSel_e  resultSelW;

    assign pcPlus4F = pcF_o + 32'd4;

    // Correction first, then prediction
    assign pcNextF = redirectE_o  ? correctPcE    :
                     predTakenF_i ? predTargetF_i : pcPlus4F;

    always_ff @(posedge clk) begin
        if (reset) begin
            pcF_o <= `PC_START;
        end else begin
            pcF_o <= pcNextF;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flushD_i) begin
            instrD_o   <= '0; // All-zero word decodes as a bubble
            predTakenD <= 1'b0;
        end else begin
            instrD_o   <= instrF_i;
            predTakenD <= predTakenF_i;
        end
        pcD         <= pcF_o;
        predTargetD <= predTargetF_i;
        phtIdxD     <= phtIdxF_i;
    end

    assign rs1D = instrD_o.rView.rs1;
    assign rs2D = instrD_o.rView.rs2;

    // Write first, then read with a bypass for the same register
    always_ff @(posedge clk) begin
        if (regWriteW_o && rdW_o != 5'd0) begin
            regFile[rdW_o] <= resultW_o;
        end
    end

    assign rd1D = (rs1D == 5'd0) ? 32'd0 :
                  (regWriteW_o && rdW_o == rs1D) ? resultW_o : regFile[rs1D];
    assign rd2D = (rs2D == 5'd0) ? 32'd0 :
                  (regWriteW_o && rdW_o == rs2D) ? resultW_o : regFile[rs2D];

    // Immediates, B type from the R view and J and U types from the I view
    always_comb begin
        case (immSelD_i)
            immB: begin
                immD = {{20{instrD_o.rView.funct7[6]}}, instrD_o.rView.rd[0],
                        instrD_o.rView.funct7[5:0], instrD_o.rView.rd[4:1], 1'b0};
            end
            immJ: begin
                immD = {{12{instrD_o.iView.imm12[11]}}, instrD_o.iView.rs1,
                        instrD_o.iView.funct3, instrD_o.iView.imm12[0],
                        instrD_o.iView.imm12[10:1], 1'b0};
            end
            immU: begin
                immD = {instrD_o.iView.imm12, instrD_o.iView.rs1,
                        instrD_o.iView.funct3, 12'd0};
            end
            default: immD = {{20{instrD_o.iView.imm12[11]}}, instrD_o.iView.imm12};
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || flushE_i) begin
            rs1E_o     <= 5'd0;
            rs2E_o     <= 5'd0;
            rdE_o      <= 5'd0;
            predTakenE <= 1'b0;
        end else begin
            rs1E_o     <= rs1D;
            rs2E_o     <= rs2D;
            rdE_o      <= instrD_o.rView.rd;
            predTakenE <= predTakenD;
        end
        pcE         <= pcD;
        predTargetE <= predTargetD;
        phtIdxE_o   <= phtIdxD;
        rd1E        <= rd1D;
        rd2E        <= rd2D;
        immE        <= immD;
    end

    assign srcAE    = (fwdAE_i == fwdWb) ? resultW_o : rd1E;
    assign srcBRegE = (fwdBE_i == fwdWb) ? resultW_o : rd2E;
    assign srcBE    = aluSrcImmE_i ? immE : srcBRegE;

    always_comb begin
        case (aluOpE_i)
            aluSub:  aluResultE = srcAE - srcBE;
            aluAnd:  aluResultE = srcAE & srcBE;
            aluOr:   aluResultE = srcAE | srcBE;
            aluXor:  aluResultE = srcAE ^ srcBE;
            aluSlt:  aluResultE = {31'd0, $signed(srcAE) < $signed(srcBE)};
            default: aluResultE = srcAE + srcBE;
        endcase
    end

    assign zeroE    = (aluResultE == 32'd0);
    assign condE    = branchNeE_i ? !zeroE : zeroE; // bne or beq sense
    assign takenE   = (isBranchE_i && condE) || isJumpE_i;
    assign pcPlus4E = pcE + 32'd4;
    assign targetE  = isJalrE_i ? {aluResultE[31:1], 1'b0} : pcE + immE;

    // Wrong direction, or taken to the wrong place
    assign redirectE_o = takenE ? (!predTakenE || predTargetE != targetE) : predTakenE;
    assign correctPcE  = takenE ? targetE : pcPlus4E;

    // Predictor training
    assign phtWeE_o     = isBranchE_i;
    assign phtIncE_o    = condE;
    assign ghrClearE_o  = redirectE_o;
    assign btbWeE_o     = takenE;
    assign btbIdxE_o    = pcE[`BTB_BITS+1:2];
    assign btbTargetE_o = targetE;

    always_ff @(posedge clk) begin
        if (reset) begin
            regWriteW_o <= 1'b0;
            rdW_o       <= 5'd0;
        end else begin
            regWriteW_o <= regWriteE_i;
            rdW_o       <= rdE_o;
        end
        aluResultW <= aluResultE;
        pcPlus4W   <= pcPlus4E;
        immW       <= immE;
        resultSelW <= resultSelE_i;
    end

    always_comb begin
        case (resultSelW)
            resPc4:  resultW_o = pcPlus4W;
            resImm:  resultW_o = immW;
            default: resultW_o = aluResultW;
        endcase
    end

endmodule

// File: source/pipeCore.sv
`include "core_defs.svh"

module pipeCore import coreTypes_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] pcF_o,
    input  logic [31:0] instrF_i,
    output logic        regWriteW_o,
    output logic [4:0]  rdW_o,
    output logic [31:0] resultW_o,
    output logic        redirect_o
);

    // Predictor links
    logic                 predTakenF;
    logic [31:0]          predTargetF;
    logic [`GHR_BITS-1:0] phtIdxF;
    logic                 phtWeE;
    logic                 phtIncE;
    logic [`GHR_BITS-1:0] phtIdxE;
    logic                 ghrClearE;
    logic                 btbWeE;
    logic [`BTB_BITS-1:0] btbIdxE;
    logic [31:0]          btbTargetE;

    // Control links
    instrWord_u instrD;
    logic [4:0] rs1E;
    logic [4:0] rs2E;
    immSel_e    immSelD;
    aluOp_e     aluOpE;
    logic       aluSrcImmE;
    resultSel_e resultSelE;
    logic       regWriteE;
    logic       isBranchE;
    logic       isJumpE;
    logic       isJalrE;
    logic       branchNeE;
    fwdSel_e    fwdAE;
    fwdSel_e    fwdBE;
    logic       flushD;
    logic       flushE;
    logic       redirectE;

    assign redirect_o = redirectE;

    branchPredictor predictor (
        .clk           (clk),
        .reset         (reset),
        .pcF_i         (pcF_o),
        .predTakenF_o  (predTakenF),
        .predTargetF_o (predTargetF),
        .phtIdxF_o     (phtIdxF),
        .phtWeE_i      (phtWeE),
        .phtIncE_i     (phtIncE),
        .phtIdxE_i     (phtIdxE),
        .ghrClearE_i   (ghrClearE),
        .btbWeE_i      (btbWeE),
        .btbIdxE_i     (btbIdxE),
        .btbTargetE_i  (btbTargetE)
    );

    controlUnit control (
        .clk          (clk),
        .reset        (reset),
        .instrD_i     (instrD),
        .rs1E_i       (rs1E),
        .rs2E_i       (rs2E),
        .rdW_i        (rdW_o),
        .regWriteW_i  (regWriteW_o),
        .redirectE_i  (redirectE),
        .immSelD_o    (immSelD),
        .aluOpE_o     (aluOpE),
        .aluSrcImmE_o (aluSrcImmE),
        .resultSelE_o (resultSelE),
        .regWriteE_o  (regWriteE),
        .isBranchE_o  (isBranchE),
        .isJumpE_o    (isJumpE),
        .isJalrE_o    (isJalrE),
        .branchNeE_o  (branchNeE),
        .fwdAE_o      (fwdAE),
        .fwdBE_o      (fwdBE),
        .flushD_o     (flushD),
        .flushE_o     (flushE)
    );

    datapath dp (
        .clk           (clk),
        .reset         (reset),
        .instrF_i      (instrF_i),
        .pcF_o         (pcF_o),
        .predTakenF_i  (predTakenF),
        .predTargetF_i (predTargetF),
        .phtIdxF_i     (phtIdxF),
        .phtWeE_o      (phtWeE),
        .phtIncE_o     (phtIncE),
        .phtIdxE_o     (phtIdxE),
        .ghrClearE_o   (ghrClearE),
        .btbWeE_o      (btbWeE),
        .btbIdxE_o     (btbIdxE),
        .btbTargetE_o  (btbTargetE),
        .instrD_o      (instrD),
        .rs1E_o        (rs1E),
        .rs2E_o        (rs2E),
        .rdE_o         (),
        .immSelD_i     (immSelD),
        .aluOpE_i      (aluOpE),
        .aluSrcImmE_i  (aluSrcImmE),
        .resultSelE_i  (resultSelE),
        .regWriteE_i   (regWriteE),
        .isBranchE_i   (isBranchE),
        .isJumpE_i     (isJumpE),
        .isJalrE_i     (isJalrE),
        .branchNeE_i   (branchNeE),
        .fwdAE_i       (fwdAE),
        .fwdBE_i       (fwdBE),
        .flushD_i      (flushD),
        .flushE_i      (flushE),
        .redirectE_o   (redirectE),
        .rdW_o         (rdW_o),
        .regWriteW_o   (regWriteW_o),
        .resultW_o     (resultW_o)
    );

endmodule

// File: tests/pipeCore_chk.sv
`include "core_defs.svh"

module pipeCore_chk (
    input logic        clk,
    input logic        reset,
    input logic [31:0] pcF_i,
    input logic        regWriteW_i,
    input logic [4:0]  rdW_i,
    input logic [31:0] resultW_i,
    input logic        redirect_i
);

    localparam int TraceLen = 31;

    logic [4:0]  expRd [TraceLen];
    logic [31:0] expVal [TraceLen];
    logic        expJump [TraceLen];
    logic [31:0] expTarget [TraceLen]; // Fetch address while a jump writes back
    int          wbIdx;
    int          failCount = 0;
    logic        wbNow;
    logic [31:0] prevPc;
    logic        prevRedirect;
    logic        sawPredictedBack;

    assign wbNow = regWriteW_i && rdW_i != 5'd0;

    task automatic expectWrite(input int idx, input logic [4:0] rd, input logic [31:0] val);
        expRd[idx]     = rd;
        expVal[idx]    = val;
        expJump[idx]   = 1'b0;
        expTarget[idx] = 32'd0;
    endtask

    task automatic expectJump(input int idx, input logic [31:0] target);
        expJump[idx]   = 1'b1;
        expTarget[idx] = target;
    endtask

    initial begin
        expectWrite(0, 5'd1, 32'h0000_0005);
        expectWrite(1, 5'd2, 32'hFFFF_FFFD);
        expectWrite(2, 5'd3, 32'h0000_0002);  // 5 + -3
        expectWrite(3, 5'd4, 32'hFFFF_FFFD);  // 2 - 5
        expectWrite(4, 5'd5, 32'h0000_0001);  // -3 < 5 signed
        expectWrite(5, 5'd6, 32'hFFFF_FFF8);
        expectWrite(6, 5'd7, 32'hFFFF_FFF8);
        expectWrite(7, 5'd8, 32'hFFFF_FFF9);
        expectWrite(8, 5'd9, 32'h1234_5000);
        expectWrite(9, 5'd10, 32'h1234_5678);
        expectWrite(10, 5'd11, 32'h0000_00F5);
        expectWrite(11, 5'd12, 32'h0000_0034);
        expectWrite(12, 5'd13, 32'h0000_0001); // -3 < -2
        expectWrite(13, 5'd14, 32'h0000_0038); // jal link
        expectJump(13, 32'h0000_0040);
        expectWrite(14, 5'd15, 32'h0000_0050);
        expectWrite(15, 5'd16, 32'h0000_0048); // jalr link
        expectJump(15, 32'h0000_0058);
        expectWrite(16, 5'd17, 32'h0000_0000);
        expectWrite(17, 5'd18, 32'h0000_000C);
        for (int i = 0; i < 12; i++) begin
            expectWrite(18 + i, 5'd17, 32'(i + 1)); // Loop counter
        end
        expectWrite(30, 5'd19, 32'h0000_000D);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wbIdx            <= 0;
            prevPc           <= pcF_i;
            prevRedirect     <= 1'b0;
            sawPredictedBack <= 1'b0;
        end else begin
            if (wbNow) begin
                wbIdx <= wbIdx + 1;
            end
            prevPc       <= pcF_i;
            prevRedirect <= redirect_i;
            if (pcF_i < prevPc && !prevRedirect) begin
                sawPredictedBack <= 1'b1; // Backward fetch from the predictor alone
            end
        end
    end

    assert property (@(posedge clk) $past(reset) |-> !regWriteW_i && !redirect_i)
        else begin
            failCount = failCount + 1;
            $error("Writeback or redirect active while reset is held");
        end

    assert property (@(posedge clk) $fell(reset) |-> pcF_i == `PC_START)
        else begin
            failCount = failCount + 1;
            $error("[ERROR] pcF_o expected %h got %h", `PC_START, $sampled(pcF_i));
        end

    assert property (@(posedge clk) disable iff (reset) wbNow |-> wbIdx < TraceLen)
        else begin
            failCount = failCount + 1;
            $error("Register write after the last expected writeback");
        end

    assert property (@(posedge clk) disable iff (reset)
                     wbNow && wbIdx < TraceLen |-> rdW_i == expRd[wbIdx])
        else begin
            failCount = failCount + 1;
            $error("[ERROR] rdW_o expected %h got %h", expRd[$sampled(wbIdx)],
                   $sampled(rdW_i));
        end

    assert property (@(posedge clk) disable iff (reset)
                     wbNow && wbIdx < TraceLen |-> resultW_i == expVal[wbIdx])
        else begin
            failCount = failCount + 1;
            $error("[ERROR] resultW_o expected %h got %h", expVal[$sampled(wbIdx)],
                   $sampled(resultW_i));
        end

    // Jump writes back one cycle after its redirect, so fetch is at the target
    assert property (@(posedge clk) disable iff (reset)
                     wbNow && wbIdx < TraceLen && expJump[wbIdx] |-> pcF_i == expTarget[wbIdx])
        else begin
            failCount = failCount + 1;
            $error("[ERROR] pcF_o expected %h got %h", expTarget[$sampled(wbIdx)],
                   $sampled(pcF_i));
        end

    assert property (@(posedge clk) disable iff (reset)
                     wbNow && wbIdx == TraceLen - 1 |-> sawPredictedBack)
        else begin
            failCount = failCount + 1;
            $error("Loop branch was never fetched backward on a correct prediction");
        end

endmodule

// File: tests/pipeCore_tb.sv
module pipeCore_tb;

    localparam int MemWords  = 64;
    localparam int WaitLimit = 300; // Cycles allowed for each wait
    localparam logic [6:0] OpImm  = 7'b0010011;
    localparam logic [6:0] OpJalr = 7'b1100111;

    logic        clk;
    logic        reset;
    logic [31:0] pcF;
    logic [31:0] instrF;
    logic        regWriteW;
    logic [4:0]  rdW;
    logic [31:0] resultW;
    logic        redirect;

    logic [31:0] imem [MemWords];
    int          wbCount;   // Writebacks to x1 and above
    int          runCycles; // Edges since reset release
    int          testsRun;
    int          testsFailed;
    int          failsSeen;
    bit          timedOut;

    pipeCore UUT (
        .clk         (clk),
        .reset       (reset),
        .pcF_o       (pcF),
        .instrF_i    (instrF),
        .regWriteW_o (regWriteW),
        .rdW_o       (rdW),
        .resultW_o   (resultW),
        .redirect_o  (redirect)
    );

    bind pipeCore pipeCore_chk chk (
        .clk         (clk),
        .reset       (reset),
        .pcF_i       (pcF_o),
        .regWriteW_i (regWriteW_o),
        .rdW_i       (rdW_o),
        .resultW_i   (resultW_o),
        .redirect_i  (redirect_o)
    );

    assign instrF = imem[pcF[7:2]]; // Fetch answers in the same cycle

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        if (reset) begin
            wbCount   <= 0;
            runCycles <= 0;
        end else begin
            runCycles <= runCycles + 1;
            if (regWriteW && rdW != 5'd0) begin
                wbCount <= wbCount + 1;
            end
        end
    end

    function automatic logic [31:0] regForm(input logic [6:0] funct7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] funct3,
                                            input logic [4:0] rd);
        return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] immForm(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] funct3, input logic [4:0] rd,
                                            input logic [6:0] op);
        return {imm, rs1, funct3, rd, op};
    endfunction

    // Byte offset whose bit 0 the format drops
    function automatic logic [31:0] branchForm(input logic [12:0] off, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] funct3);
        return {off[12], off[10:5], rs2, rs1, funct3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jalForm(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] luiForm(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    task automatic loadProgram();
        // Unused words hold a harmless addi x0 carrying their own index
        for (int i = 0; i < MemWords; i++) begin
            imem[i] = immForm(12'(i), 5'd0, 3'b000, 5'd0, OpImm);
        end
        imem[0]  = immForm(12'd5, 5'd0, 3'b000, 5'd1, OpImm);      // addi x1, x0, 5
        imem[1]  = immForm(12'hFFD, 5'd0, 3'b000, 5'd2, OpImm);    // addi x2, x0, -3
        imem[2]  = regForm(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);       // add  x3, x1, x2
        imem[3]  = regForm(7'h20, 5'd1, 5'd3, 3'b000, 5'd4);       // sub  x4, x3, x1
        imem[4]  = regForm(7'h00, 5'd1, 5'd4, 3'b010, 5'd5);       // slt  x5, x4, x1
        imem[5]  = regForm(7'h00, 5'd1, 5'd4, 3'b100, 5'd6);       // xor  x6, x4, x1
        imem[6]  = regForm(7'h00, 5'd2, 5'd6, 3'b111, 5'd7);       // and  x7, x6, x2
        imem[7]  = regForm(7'h00, 5'd5, 5'd7, 3'b110, 5'd8);       // or   x8, x7, x5
        imem[8]  = luiForm(20'h12345, 5'd9);                       // lui  x9, 0x12345
        imem[9]  = immForm(12'h678, 5'd9, 3'b100, 5'd10, OpImm);   // xori x10, x9, 0x678
        imem[10] = immForm(12'h0F0, 5'd1, 3'b110, 5'd11, OpImm);   // ori  x11, x1, 0xf0
        imem[11] = immForm(12'h03C, 5'd11, 3'b111, 5'd12, OpImm);  // andi x12, x11, 0x3c
        imem[12] = immForm(12'hFFE, 5'd2, 3'b010, 5'd13, OpImm);   // slti x13, x2, -2
        imem[13] = jalForm(21'd12, 5'd14);                         // jal  x14, 0x40
        imem[14] = immForm(12'd1, 5'd0, 3'b000, 5'd20, OpImm);     // Skipped
        imem[15] = immForm(12'd1, 5'd0, 3'b000, 5'd21, OpImm);     // Skipped
        imem[16] = immForm(12'h050, 5'd0, 3'b000, 5'd15, OpImm);   // addi x15, x0, 0x50
        imem[17] = immForm(12'd8, 5'd15, 3'b000, 5'd16, OpJalr);   // jalr x16, 8(x15)
        for (int i = 0; i < 4; i++) begin
            imem[18 + i] = immForm(12'd1, 5'd0, 3'b000, 5'(22 + i), OpImm); // Skipped
        end
        imem[22] = immForm(12'd0, 5'd0, 3'b000, 5'd17, OpImm);     // addi x17, x0, 0
        imem[23] = immForm(12'd12, 5'd0, 3'b000, 5'd18, OpImm);    // addi x18, x0, 12
        imem[24] = immForm(12'd1, 5'd17, 3'b000, 5'd17, OpImm);    // addi x17, x17, 1
        imem[25] = branchForm(13'h1FFC, 5'd18, 5'd17, 3'b001);     // bne  x17, x18, -4
        imem[26] = branchForm(13'd8, 5'd18, 5'd17, 3'b000);        // beq  x17, x18, +8
        imem[27] = immForm(12'd1, 5'd0, 3'b000, 5'd26, OpImm);     // Skipped
        imem[28] = regForm(7'h00, 5'd13, 5'd17, 3'b000, 5'd19);    // add  x19, x17, x13
        imem[29] = jalForm(21'd0, 5'd0);                           // Park in a self loop
    endtask

    // Either the writeback count or the cycle count reaches target
    task automatic awaitProgress(input bit byWrites, input int target);
        int cycles;
        int seen;
        cycles = 0;
        seen   = byWrites ? wbCount : runCycles;
        while (seen < target && cycles < WaitLimit) begin
            @(negedge clk);
            cycles++;
            seen = byWrites ? wbCount : runCycles;
        end
        if (seen < target) begin
            timedOut = 1'b1;
            $display("Timeout after %0d cycles, reached %0d of %0d %s", WaitLimit, seen,
                     target, byWrites ? "writebacks" : "cycles");
        end
    endtask

    task automatic runTest(input string name, input bit byWrites, input int target);
        int newFails;
        if (!timedOut) begin
            awaitProgress(byWrites, target);
            newFails  = UUT.chk.failCount - failsSeen;
            failsSeen = UUT.chk.failCount;
            testsRun++;
            if (timedOut || newFails != 0) begin
                testsFailed++;
                $display("Test %s FAIL with %0d assertion failures", name, newFails);
            end else begin
                $display("Test %s ok", name);
            end
        end
    endtask

    initial begin
        reset       = 1'b1;
        testsRun    = 0;
        testsFailed = 0;
        failsSeen   = 0;
        timedOut    = 1'b0;
        loadProgram();
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        runTest("reset", 1'b0, 1);         // Start PC seen on the first edge out of reset
        runTest("aluOps", 1'b1, 9);        // Up to lui
        runTest("forwarding", 1'b1, 13);
        runTest("jumps", 1'b1, 16);
        runTest("branchLoop", 1'b1, 31);
        runTest("drain", 1'b0, runCycles + 4); // Parking jump passes writeback, no write follows

        $display("Tests run %0d, failed %0d, assertion failures %0d", testsRun, testsFailed,
                 UUT.chk.failCount);
        if (testsFailed == 0 && !timedOut && UUT.chk.failCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+include
source/coreTypes_pkg.sv
source/branchPredictor.sv
source/controlUnit.sv
source/datapath.sv
source/pipeCore.sv
tests/pipeCore_chk.sv
tests/pipeCore_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --assert -j 0
TOP       := pipeCore_tb
FILELIST  := build.f
OBJDIR    := obj_dir
RUNFLAGS  := +verilator+error+limit+1000
PASS_MSG  := Simulation passed

SIM       := $(OBJDIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
HEADERS   := $(wildcard include/*.svh)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source, header or the file list changes
$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(SIM)
	@out="$$(./$(SIM) $(RUNFLAGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
